/* source/positPkg.sv */
/*
  shared constants and vector types for the posit add/subtract pipeline
  field widths that follow N and ES are sized inside each module
*/
`default_nettype none

package positPkg;

    ////////////////////
    // default format
    ////////////////////

    // posit width and exponent size used unless the top is overridden
    localparam int DEFAULT_N  = 16;
    localparam int DEFAULT_ES = 1;

    // widest posit the shift type has to cover
    localparam int MAX_N = 32;

    ////////////////////
    // shared types
    ////////////////////

    // normalization shift from the leading-bit detector
    typedef logic signed [$clog2(MAX_N):0] shiftT;

    // special-value flags, one bit each
    typedef logic [1:0] flagsT;

    // bit positions inside flagsT
    localparam int FLAG_ZERO = 0;
    localparam int FLAG_NAR  = 1;

endpackage

`default_nettype wire

/* source/leadingBitDetector.sv */
/*
  distance of the highest set bit from the top of bits, N when bits is zero
  at N = MAX_N the all-zero code wraps in shiftT; callers treat it as zero
*/
`timescale 1ns/100ps
`default_nettype none

module leadingBitDetector #(
    parameter int N = 16
) (
    input  logic [N-1:0]    bits,
    output positPkg::shiftT position
);

    ////////////////////
    // priority encoder
    ////////////////////

    always_comb
    begin
        // nothing set yet, full width shift
        position = positPkg::shiftT'(N);

        // scan upward so the highest one wins
        for (int i = 0; i < N; i++)
        begin
            if (bits[i])
                position = positPkg::shiftT'(N - 1 - i);
        end
    end

endmodule

`default_nettype wire

/* source/positDecoder.sv */
/*
  one-cycle decode of two posits into sign, regime, exponent, mantissa, key
  needs ES >= 1; sub flips only the registered sign of B, not its fields
*/
`timescale 1ns/100ps
`default_nettype none

module positDecoder #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    input  logic [N-1:0]          operandA,
    input  logic [N-1:0]          operandB,
    input  logic                  sub,
    output logic                  decValid,
    output logic                  signA,
    output logic                  signB,
    output logic signed [$clog2(N):0] kA,
    output logic signed [$clog2(N):0] kB,
    output logic [ES-1:0]         expA,
    output logic [ES-1:0]         expB,
    output logic [N-1:0]          mantA,
    output logic [N-1:0]          mantB,
    output logic [N-2:0]          keyA,
    output logic [N-2:0]          keyB,
    output positPkg::flagsT       flagsA,
    output positPkg::flagsT       flagsB
);

    localparam int RS = $clog2(N);

    // index 0 is operand A, index 1 is operand B
    logic [1:0][N-1:0]   operand;
    logic [1:0][N-1:0]   mag;
    logic [1:0][N-2:0]   body;
    logic [1:0][N-2:0]   rem;
    logic [1:0][RS:0]    runLen;
    logic [1:0][RS:0]    kNext;
    logic [1:0][ES-1:0]  expNext;
    logic [1:0][N-1:0]   mantNext;
    positPkg::flagsT     flagsNext [2];

    ////////////////////
    // field extraction
    ////////////////////

    always_comb
    begin : decodeBoth
        logic stop;
        operand[0] = operandA;
        operand[1] = operandB;
        for (int i = 0; i < 2; i++)
        begin
            // negative posits decode from their two's complement
            mag[i]  = operand[i][N-1] ? -operand[i] : operand[i];
            body[i] = mag[i][N-2:0];

            // length of the regime run, counted from the top
            runLen[i] = '0;
            stop      = 1'b0;
            for (int j = N - 2; j >= 0; j--)
            begin
                if (!stop && (body[i][j] == body[i][N-2]))
                    runLen[i] = runLen[i] + 1'b1;
                else
                    stop = 1'b1;
            end

            // run of ones gives k = m-1, run of zeros gives k = -m
            kNext[i] = body[i][N-2] ? runLen[i] - 1'b1 : -runLen[i];

            // drop regime and terminator, exponent then fraction remain
            rem[i]      = body[i] << (runLen[i] + 1);
            expNext[i]  = rem[i][N-2 -: ES];
            mantNext[i] = {1'b1, rem[i][N-2-ES:0], {ES{1'b0}}};

            // zero is all zeros, NaR is a one then all zeros
            flagsNext[i][positPkg::FLAG_ZERO] = (operand[i] == '0);
            flagsNext[i][positPkg::FLAG_NAR]  = (operand[i] == {1'b1, {(N-1){1'b0}}});
        end
    end

    ////////////////////
    // stage register
    ////////////////////

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            decValid <= 1'b0;
            signA    <= 1'b0;
            signB    <= 1'b0;
            kA       <= '0;
            kB       <= '0;
            expA     <= '0;
            expB     <= '0;
            mantA    <= '0;
            mantB    <= '0;
            keyA     <= '0;
            keyB     <= '0;
            flagsA   <= '0;
            flagsB   <= '0;
        end
        else
        begin
            decValid <= inValid;
            signA    <= operandA[N-1];
            // subtraction is addition with B negated
            signB    <= operandB[N-1] ^ sub;
            kA       <= kNext[0];
            kB       <= kNext[1];
            expA     <= expNext[0];
            expB     <= expNext[1];
            mantA    <= mantNext[0];
            mantB    <= mantNext[1];
            keyA     <= mag[0][N-2:0];
            keyB     <= mag[1][N-2:0];
            flagsA   <= flagsNext[0];
            flagsB   <= flagsNext[1];
        end
    end

endmodule

`default_nettype wire

/* source/addSubtract.sv */
/*
  one-cycle align, add or subtract, and renormalize of two decoded posits
  the smaller mantissa is shifted at most 2N places
  shifted-out bits fold into a sticky bit
*/
`timescale 1ns/100ps
`default_nettype none

module addSubtract #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          decValid,
    input  logic                          signA,
    input  logic                          signB,
    input  logic signed [$clog2(N):0]     kA,
    input  logic signed [$clog2(N):0]     kB,
    input  logic [ES-1:0]                 expA,
    input  logic [ES-1:0]                 expB,
    input  logic [N-1:0]                  mantA,
    input  logic [N-1:0]                  mantB,
    input  logic [N-2:0]                  keyA,
    input  logic [N-2:0]                  keyB,
    input  positPkg::flagsT               flagsA,
    input  positPkg::flagsT               flagsB,
    output logic                          addValid,
    output logic                          resSign,
    output logic signed [$clog2(N)+ES+1:0] resScale,
    output logic [2*N-1:0]                resMant,
    output positPkg::flagsT               resFlags
);

    localparam int RS = $clog2(N);
    localparam int SW = RS + ES + 2;

    // combined scale k*2^ES + exp of each operand
    logic signed [SW-1:0] scaleA;
    logic signed [SW-1:0] scaleB;
    // L is the larger magnitude and S the smaller
    logic                 aLarger;
    logic                 signL;
    logic                 signS;
    logic signed [SW-1:0] scaleL;
    logic signed [SW-1:0] scaleS;
    logic signed [SW-1:0] scaleDiff;
    logic [2*N-1:0]       lmFull;
    logic [2*N-1:0]       smFull;
    logic [2*N-1:0]       smAligned;
    logic [2*N-1:0]       lostBits;
    logic                 effSub;
    logic [2*N:0]         sum;
    logic                 ovf;
    positPkg::shiftT      position;
    logic                 zeroA;
    logic                 zeroB;
    logic                 signNext;
    logic signed [SW-1:0] scaleNext;
    logic [2*N-1:0]       mantNext;
    positPkg::flagsT      flagsNext;

    // leading one of the upper half after a subtraction
    leadingBitDetector #(.N(N)) uLbd (
        .bits     (sum[2*N-1:N]),
        .position (position)
    );

    ////////////////////
    // align and add
    ////////////////////

    always_comb
    begin
        scaleA = $signed({kA, expA});
        scaleB = $signed({kB, expB});

        // the magnitude key orders the operands
        aLarger = (keyA >= keyB);
        signL   = aLarger ? signA : signB;
        signS   = aLarger ? signB : signA;
        scaleL  = aLarger ? scaleA : scaleB;
        scaleS  = aLarger ? scaleB : scaleA;
        lmFull  = aLarger ? {mantA, {N{1'b0}}} : {mantB, {N{1'b0}}};
        smFull  = aLarger ? {mantB, {N{1'b0}}} : {mantA, {N{1'b0}}};

        // never negative since the key follows the scale
        scaleDiff = scaleL - scaleS;

        // smaller mantissa moved right with lost bits kept as sticky
        lostBits = '0;
        if (scaleDiff >= 2 * N)
        begin
            smAligned = {{(2*N-1){1'b0}}, |smFull};
        end
        else
        begin
            smAligned    = smFull >> scaleDiff;
            lostBits     = smFull << (2 * N - scaleDiff);
            smAligned[0] = smAligned[0] | (|lostBits);
        end

        // unlike signs subtract
        effSub = signL ^ signS;
        if (effSub)
            sum = {1'b0, lmFull} - {1'b0, smAligned};
        else
            sum = {1'b0, lmFull} + {1'b0, smAligned};
        ovf = sum[2*N];
    end

    ////////////////////
    // normalize
    ////////////////////

    always_comb
    begin
        zeroA = flagsA[positPkg::FLAG_ZERO];
        zeroB = flagsB[positPkg::FLAG_ZERO];

        // a carry out moves the point one place up
        // otherwise the leading one is shifted to the top
        signNext = signL;
        if (ovf)
        begin
            mantNext  = {sum[2*N:2], sum[1] | sum[0]};
            scaleNext = scaleL + 1;
        end
        else
        begin
            mantNext  = sum[2*N-1:0] << position;
            scaleNext = scaleL - position;
        end

        flagsNext                      = '0;
        flagsNext[positPkg::FLAG_NAR]  = flagsA[positPkg::FLAG_NAR] | flagsB[positPkg::FLAG_NAR];
        flagsNext[positPkg::FLAG_ZERO] = (zeroA & zeroB) | (!zeroA && !zeroB && (sum == '0));

        // a single zero operand leaves the other one as it is
        if (zeroA && !zeroB)
        begin
            signNext  = signB;
            scaleNext = scaleB;
            mantNext  = {mantB, {N{1'b0}}};
        end
        else if (zeroB && !zeroA)
        begin
            signNext  = signA;
            scaleNext = scaleA;
            mantNext  = {mantA, {N{1'b0}}};
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            addValid <= 1'b0;
            resSign  <= 1'b0;
            resScale <= '0;
            resMant  <= '0;
            resFlags <= '0;
        end
        else
        begin
            addValid <= decValid;
            resSign  <= signNext;
            resScale <= scaleNext;
            resMant  <= mantNext;
            resFlags <= flagsNext;
        end
    end

endmodule

`default_nettype wire

/* source/positEncoder.sv */
/*
  one-cycle posit packing with round to nearest even
  results clamp to maxpos or minpos; only the flags give zero or NaR
*/
`timescale 1ns/100ps
`default_nettype none

module positEncoder #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          addValid,
    input  logic                          resSign,
    input  logic signed [$clog2(N)+ES+1:0] resScale,
    input  logic [2*N-1:0]                resMant,
    input  positPkg::flagsT               resFlags,
    output logic                          outValid,
    output logic [N-1:0]                  result
);

    localparam int RS = $clog2(N);
    localparam int SW = RS + ES + 2;
    // regime head, exponent, fraction and room for the regime run
    localparam int ZW = 3 * N + ES + 1;

    localparam logic [N-2:0] MAXPOS_BODY = {(N-1){1'b1}};
    localparam logic [N-2:0] MINPOS_BODY = {{(N-2){1'b0}}, 1'b1};

    logic signed [SW-1:0] regimeK;
    logic [ES-1:0]        expBits;
    logic [SW-1:0]        shiftAmt;
    logic [ZW-1:0]        padded;
    logic [ZW-1:0]        shifted;
    logic [N-2:0]         bodyBits;
    logic                 guardBit;
    logic                 stickyBit;
    logic                 roundUp;
    logic                 carry;
    logic [N-2:0]         bodyRounded;
    logic [N-2:0]         bodyFinal;
    logic [N-1:0]         resultNext;

    ////////////////////
    // regime build
    ////////////////////

    always_comb
    begin
        // floor split of the scale, low ES bits are the exponent
        regimeK = resScale >>> ES;
        expBits = resScale[ES-1:0];

        // head 10 grows into k+1 ones, head 01 into -k zeros
        shiftAmt = (regimeK >= 0) ? regimeK : -regimeK - 1;
        padded   = {(regimeK >= 0) ? 2'b10 : 2'b01, expBits, resMant[2*N-2:0], {N{1'b0}}};
        // sign fill copies the first regime bit
        shifted  = $signed(padded) >>> shiftAmt;

        bodyBits  = shifted[ZW-1 -: N-1];
        guardBit  = shifted[ZW-N];
        stickyBit = |shifted[ZW-N-1:0];
    end

    ////////////////////
    // round and pack
    ////////////////////

    always_comb
    begin
        // ties go to the even body
        roundUp              = guardBit & (stickyBit | bodyBits[0]);
        {carry, bodyRounded} = {1'b0, bodyBits} + roundUp;

        // out of range scales saturate
        if (regimeK > N - 2)
            bodyFinal = MAXPOS_BODY;
        else if (regimeK < -(N - 2))
            bodyFinal = MINPOS_BODY;
        else if (carry)
            bodyFinal = MAXPOS_BODY;
        else
            bodyFinal = bodyRounded;

        // negative values in two's complement
        if (resSign)
            resultNext = -{1'b0, bodyFinal};
        else
            resultNext = {1'b0, bodyFinal};

        // special values win
        if (resFlags[positPkg::FLAG_NAR])
            resultNext = {1'b1, {(N-1){1'b0}}};
        else if (resFlags[positPkg::FLAG_ZERO])
            resultNext = '0;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            outValid <= 1'b0;
            result   <= '0;
        end
        else
        begin
            outValid <= addValid;
            result   <= resultNext;
        end
    end

endmodule

`default_nettype wire

/* source/positAdderTop.sv */
/*
  three-stage posit adder, result three cycles after inValid
  no back-pressure, one operand pair may enter every cycle
*/
`timescale 1ns/100ps
`default_nettype none

module positAdderTop #(
    parameter int N  = positPkg::DEFAULT_N,
    parameter int ES = positPkg::DEFAULT_ES
) (
    input  logic         clk,
    input  logic         arstN,
    input  logic         inValid,
    input  logic [N-1:0] operandA,
    input  logic [N-1:0] operandB,
    input  logic         sub,
    output logic         outValid,
    output logic [N-1:0] result
);

    localparam int RS = $clog2(N);
    localparam int SW = RS + ES + 2;

    // decode to add stage
    logic                 decValid;
    logic                 signA;
    logic                 signB;
    logic signed [RS:0]   kA;
    logic signed [RS:0]   kB;
    logic [ES-1:0]        expA;
    logic [ES-1:0]        expB;
    logic [N-1:0]         mantA;
    logic [N-1:0]         mantB;
    logic [N-2:0]         keyA;
    logic [N-2:0]         keyB;
    positPkg::flagsT      flagsA;
    positPkg::flagsT      flagsB;

    // add stage to encoder
    logic                 addValid;
    logic                 resSign;
    logic signed [SW-1:0] resScale;
    logic [2*N-1:0]       resMant;
    positPkg::flagsT      resFlags;

    ////////////////////
    // pipeline stages
    ////////////////////

    positDecoder #(.N(N), .ES(ES)) uDecoder (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .operandA (operandA),
        .operandB (operandB),
        .sub      (sub),
        .decValid (decValid),
        .signA    (signA),
        .signB    (signB),
        .kA       (kA),
        .kB       (kB),
        .expA     (expA),
        .expB     (expB),
        .mantA    (mantA),
        .mantB    (mantB),
        .keyA     (keyA),
        .keyB     (keyB),
        .flagsA   (flagsA),
        .flagsB   (flagsB)
    );

    addSubtract #(.N(N), .ES(ES)) uAddSub (
        .clk      (clk),
        .arstN    (arstN),
        .decValid (decValid),
        .signA    (signA),
        .signB    (signB),
        .kA       (kA),
        .kB       (kB),
        .expA     (expA),
        .expB     (expB),
        .mantA    (mantA),
        .mantB    (mantB),
        .keyA     (keyA),
        .keyB     (keyB),
        .flagsA   (flagsA),
        .flagsB   (flagsB),
        .addValid (addValid),
        .resSign  (resSign),
        .resScale (resScale),
        .resMant  (resMant),
        .resFlags (resFlags)
    );

    positEncoder #(.N(N), .ES(ES)) uEncoder (
        .clk      (clk),
        .arstN    (arstN),
        .addValid (addValid),
        .resSign  (resSign),
        .resScale (resScale),
        .resMant  (resMant),
        .resFlags (resFlags),
        .outValid (outValid),
        .result   (result)
    );

endmodule

`default_nettype wire

/* testbench/positAdder_assertions.sv */
/*
  timing and reset checks bound into positAdderTop
  failCount is read by the testbench at the end of the run
*/
`timescale 1ns/100ps
`default_nettype none

module positAdderAssertions #(
    parameter int N = 16
) (
    input logic         clk,
    input logic         arstN,
    input logic         inValid,
    input logic         outValid,
    input logic [N-1:0] result
);

    int failCount = 0;

    ////////////////////
    // strobe timing
    ////////////////////

    // every accepted pair comes out three edges later
    validToResult: assert property (@(posedge clk) disable iff (!arstN)
        inValid |-> ##3 outValid)
    else
    begin
        failCount++;
        $error("outValid missing three cycles after inValid");
    end

    // and nothing comes out without one
    resultFromValid: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> $past(inValid, 3))
    else
    begin
        failCount++;
        $error("outValid without inValid three cycles earlier");
    end

    ////////////////////
    // reset state
    ////////////////////

    quietInReset: assert property (@(posedge clk) !arstN |-> !outValid)
    else
    begin
        failCount++;
        $error("outValid high during reset");
    end

    quietAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !outValid ##1 !outValid)
    else
    begin
        failCount++;
        $error("outValid high right after reset");
    end

    // result known whenever it is marked valid
    knownResult: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> !$isunknown(result))
    else
    begin
        failCount++;
        $error("result unknown while outValid is high");
    end

endmodule

bind positAdderTop positAdderAssertions #(.N(N)) assertChecks (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .outValid (outValid),
    .result   (result)
);

`default_nettype wire

/* testbench/positAdderTb.sv */
/*
  testbench for the posit adder at N=16, ES=1, inputs driven 1 ns after the rising edge
  results checked in issue order through a queue, bound assertions cover the timing
*/
`timescale 1ns/100ps
`default_nettype none

module positAdderTb;

    localparam int N       = positPkg::DEFAULT_N;
    localparam int ES      = positPkg::DEFAULT_ES;
    localparam int TIMEOUT = 50;

    // special encodings
    localparam logic [N-1:0] NAR    = {1'b1, {(N-1){1'b0}}};
    localparam logic [N-1:0] MAXPOS = {1'b0, {(N-1){1'b1}}};

    logic         clk;
    logic         arstN;
    logic         inValid;
    logic [N-1:0] operandA;
    logic [N-1:0] operandB;
    logic         sub;
    logic         outValid;
    logic [N-1:0] result;

    integer seed;
    int     checkCount  = 0;
    int     valueErrors = 0;
    int     otherErrors = 0;

    // one entry per operation in flight
    logic [N-1:0] expQ[$];
    bit           checkQ[$];
    string        nameQ[$];
    // every result in arrival order
    logic [N-1:0] gotQ[$];

    positAdderTop #(.N(N), .ES(ES)) u_dut (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .operandA (operandA),
        .operandB (operandB),
        .sub      (sub),
        .outValid (outValid),
        .result   (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    // any posit except NaR
    function automatic logic [N-1:0] randomReal();
        logic [N-1:0] v;
        v = $random(seed);
        if (v == NAR)
            v = v + 1'b1;
        return v;
    endfunction

    task automatic checkValue(input string name, input logic [N-1:0] expected,
                              input logic [N-1:0] actual);
        checkCount++;
        assert (actual === expected)
        else
        begin
            valueErrors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic flushQueues();
        expQ.delete();
        checkQ.delete();
        nameQ.delete();
    endtask

    // one operation per call, called 1 ns after a rising edge
    task automatic send(input logic [N-1:0] a, input logic [N-1:0] b, input logic s,
                        input logic [N-1:0] expected, input bit checkIt, input string name);
        operandA = a;
        operandB = b;
        sub      = s;
        inValid  = 1'b1;
        expQ.push_back(expected);
        checkQ.push_back(checkIt);
        nameQ.push_back(name);
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    task automatic applyReset();
        arstN = 1'b0;
        // anything in flight is lost
        flushQueues();
        repeat (2) @(posedge clk);
        #1;
        arstN = 1'b1;
    endtask

    // wait for every pending result
    task automatic drain(input string phase);
        int cycles;
        cycles = 0;
        while (expQ.size() != 0 && cycles < TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        #1;
        if (expQ.size() != 0)
        begin
            otherErrors++;
            $display("%s: %0d results never came out of the pipeline", phase, expQ.size());
            flushQueues();
        end
    endtask

    // results sampled mid-cycle, away from the edge
    always @(negedge clk)
    begin : collect
        logic [N-1:0] expected;
        bit           checkIt;
        string        name;
        if (arstN && outValid)
        begin
            if (expQ.size() == 0)
            begin
                otherErrors++;
                $display("result %h came out with no operation pending", result);
            end
            else
            begin
                expected = expQ.pop_front();
                checkIt  = checkQ.pop_front();
                name     = nameQ.pop_front();
                if (checkIt)
                    checkValue(name, expected, result);
                gotQ.push_back(result);
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial
    begin : stimulus
        logic [N-1:0] x;
        logic [N-1:0] a;
        logic [N-1:0] b;
        int           assertErrors;
        seed     = 51;
        arstN    = 1'b1;
        inValid  = 1'b0;
        operandA = '0;
        operandB = '0;
        sub      = 1'b0;
        #1;
        applyReset();

        // x plus zero in both positions
        repeat (20)
        begin
            x = randomReal();
            send(x, '0, 1'b0, x, 1'b1, "identity x+0");
            send('0, x, 1'b0, x, 1'b1, "identity 0+x");
        end
        drain("identity");

        // x-x and x+(-x)
        repeat (20)
        begin
            x = randomReal();
            send(x, x, 1'b1, '0, 1'b1, "cancel x-x");
            send(x, -x, 1'b0, '0, 1'b1, "cancel x+(-x)");
        end
        drain("cancellation");

        // NaR wins in every position, zero included
        send(NAR, '0, 1'b0, NAR, 1'b1, "nar NaR+0");
        send('0, NAR, 1'b1, NAR, 1'b1, "nar 0-NaR");
        repeat (10)
        begin
            x = $random(seed);
            send(NAR, x, 1'b0, NAR, 1'b1, "nar NaR+x");
            send(x, NAR, 1'b0, NAR, 1'b1, "nar x+NaR");
            send(NAR, x, 1'b1, NAR, 1'b1, "nar NaR-x");
            send(x, NAR, 1'b1, NAR, 1'b1, "nar x-NaR");
        end
        drain("nar");

        // exact sums, the last one saturates
        send(16'h4000, 16'h4000, 1'b0, 16'h5000, 1'b1, "table 1+1");
        send(16'h4000, 16'h3000, 1'b0, 16'h4800, 1'b1, "table 1+0.5");
        send(16'h5000, 16'h4000, 1'b1, 16'h4000, 1'b1, "table 2-1");
        send(MAXPOS, MAXPOS, 1'b0, MAXPOS, 1'b1, "table maxpos+maxpos");
        drain("table");

        // four operations per pair, compared after the stream
        gotQ.delete();
        repeat (16)
        begin
            a = $random(seed);
            b = $random(seed);
            send(a, b, 1'b0, '0, 1'b0, "a+b");
            send(b, a, 1'b0, '0, 1'b0, "b+a");
            send(a, b, 1'b1, '0, 1'b0, "a-b");
            send(b, a, 1'b1, '0, 1'b0, "b-a");
        end
        drain("symmetry");
        if (gotQ.size() != 64)
        begin
            otherErrors++;
            $display("symmetry stream returned %0d results instead of 64", gotQ.size());
        end
        else
        begin
            for (int i = 0; i < 16; i++)
            begin
                checkValue("symmetry a+b", gotQ[4*i+1], gotQ[4*i]);
                checkValue("symmetry a-b", -gotQ[4*i+3], gotQ[4*i+2]);
            end
        end

        // reset with operations still in the pipeline
        repeat (3)
        begin
            x = randomReal();
            send(x, '0, 1'b0, x, 1'b1, "before reset");
        end
        applyReset();
        repeat (6)
        begin
            x = randomReal();
            send('0, x, 1'b0, x, 1'b1, "after reset");
        end
        drain("after reset");
        repeat (4) @(posedge clk);

        assertErrors = u_dut.assertChecks.failCount;
        $display("checks %0d, value errors %0d, missing or stray results %0d, assertion failures %0d",
                 checkCount, valueErrors, otherErrors, assertErrors);
        if (valueErrors == 0 && otherErrors == 0 && assertErrors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
source/positPkg.sv
source/leadingBitDetector.sv
source/positDecoder.sv
source/addSubtract.sv
source/positEncoder.sv
source/positAdderTop.sv
testbench/positAdder_assertions.sv
testbench/positAdderTb.sv
